// File: Makefile
# Verilator build and run of the ZX host testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check sim.log for the pass message"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -f tb.f --top-module tb_zx_host
	./obj_dir/Vtb_zx_host > sim.log
	@cat sim.log
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: include/zx_host_params.svh
/*
 * ZX Spectrum 128K host core constants
 * Bus widths, port decode, fixed bank numbers, ROM placement and turbo masks
 */
`ifndef ZX_HOST_PARAMS_SVH
`define ZX_HOST_PARAMS_SVH

// Bus widths
`define ZX_ADDR_W        16
`define ZX_DATA_W        8
`define ZX_RAM_ADDR_W    18
`define ZX_BANK_W        3
`define ZX_TURBO_W       5

// RAM banks occupy the lower 128K, ROM 0 and ROM 1 sit above them
`define ZX_ROM_BASE      18'h20000
`define ZX_BANK_4000     3'd5
`define ZX_BANK_8000     3'd2

// 7FFD decodes on A15 and A1 both low
`define ZX_PAGE_PORT(a)  (((a) & 16'h8002) == 16'h0000)

// Falling-phase ticks held off after a turbo change
`define ZX_SETTLE_TICKS  3

// Turbo masks, a wider mask gives a slower CPU
`define ZX_TURBO_1X      5'b11111
`define ZX_TURBO_2X      5'b01111
`define ZX_TURBO_4X      5'b00111
`define ZX_TURBO_8X      5'b00011
`define ZX_TURBO_16X     5'b00001

`endif

// File: tb.f
+incdir+include
verilog/zx_host_pkg.sv
verilog/ce_timer.sv
verilog/cpu_enable_fsm.sv
verilog/memory_pager.sv
verilog/ula_port.sv
verilog/zx_host_top.sv
testbench/tb_zx_host.sv

// File: testbench/tb_zx_host.sv
/*
 * Testbench for the ZX host core
 * Directed tests of paging, ULA port, read data, turbo ticks, pause and RAM wait
 */
`include "zx_host_params.svh"

module tb_zx_host
	import zx_host_pkg::*;
();

	localparam ram_addr_t PAGE_SIZE = 18'h04000;

	// Worst case length of each test group, doubled for the run limit
	localparam int BUS_CYCLES   = 3 * 9 + 100;
	localparam int TURBO_CYCLES = 5 * 32 + 8 * (32 + 16 + 8 + 4 + 2);
	localparam int WAIT_CYCLES  = 2 * 99 + 64 + 2 * 15 + 128 + 99;
	localparam int CYCLE_LIMIT  = 2 * (BUS_CYCLES + TURBO_CYCLES + WAIT_CYCLES);

	logic       clk_sys;
	logic       reset;
	cpu_bus_t   bus;
	logic [2:0] turbo_sel;
	logic       pause;
	logic       machine_48k;
	logic [4:0] key_row;
	logic       tape_in;
	cpu_data_t  ram_dout;
	logic       ram_ready;
	ram_req_t   ram_req;
	cpu_data_t  cpu_din;
	ula_out_t   ula_out;
	logic       ce_cpu_p;
	logic       ce_cpu_n;

	int          value_errors = 0;
	int          other_errors = 0;
	int          cycle_count = 0;
	logic [15:0] lfsr = 16'd37119;

	zx_host_top dut_i (
		.clk_sys, .reset, .bus, .turbo_sel, .pause, .machine_48k, .key_row, .tape_in,
		.ram_dout, .ram_ready, .ram_req, .cpu_din, .ula_out, .ce_cpu_p, .ce_cpu_n
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	// ==========================================================
	// Helpers
	// ==========================================================

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
		end
		return val;
	endfunction

	function automatic cpu_addr_t rand_addr(input logic [1:0] region);
		return {region, 14'(rand_bits(14))};
	endfunction

	// Physical address for a CPU address under a given bank and ROM select
	function automatic ram_addr_t expected_map(input cpu_addr_t addr, input bank_t bank,
			input logic rom);
		ram_addr_t offset;
		ram_addr_t result;
		offset = ram_addr_t'(addr[13:0]);
		case (addr[15:14])
			2'b00:   result = `ZX_ROM_BASE + ram_addr_t'(rom) * PAGE_SIZE + offset;
			2'b01:   result = ram_addr_t'(5) * PAGE_SIZE + offset;
			2'b10:   result = ram_addr_t'(2) * PAGE_SIZE + offset;
			default: result = ram_addr_t'(bank) * PAGE_SIZE + offset;
		endcase
		return result;
	endfunction

	// Cycles between rising CPU ticks for each speed select
	function automatic int expected_period(input int sel);
		case (sel)
			0:       return 32;
			1:       return 16;
			2:       return 8;
			3:       return 4;
			default: return 2;
		endcase
	endfunction

	task automatic check_ram_req(input string name, input ram_req_t got, input ram_req_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ula(input string name, input ula_out_t got, input ula_out_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			value_errors++;
			$display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic drive_bus(input cpu_addr_t addr, input cpu_data_t data, input logic mreq,
			input logic iorq, input logic rd, input logic wr);
		bus = '{addr, data, mreq, iorq, rd, wr, 1'b0};
	endtask

	task automatic apply_reset(input logic m48);
		@(negedge clk_sys);
		reset       = 1'b1;
		machine_48k = m48;
		bus         = '0;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// Hold the write for three cycles like a Z80 I/O cycle
	task automatic io_write(input cpu_addr_t addr, input cpu_data_t data);
		@(negedge clk_sys);
		drive_bus(addr, data, 1'b0, 1'b1, 1'b0, 1'b1);
		repeat (3) @(negedge clk_sys);
		bus = '0;
	endtask

	task automatic mem_access_check(input cpu_addr_t addr, input logic write, input bank_t bank,
			input logic rom);
		ram_req_t  exp;
		cpu_data_t data;
		data = cpu_data_t'(rand_bits(8));
		@(negedge clk_sys);
		drive_bus(addr, data, 1'b1, 1'b0, ~write, write);
		#25;
		exp.addr = expected_map(addr, bank, rom);
		exp.din  = data;
		exp.rd   = ~write;
		// ROM area never sees a write strobe
		exp.we   = write && addr >= 16'h4000;
		check_ram_req("ram_req", ram_req, exp);
	endtask

	task automatic check_map(input bank_t bank, input logic rom);
		mem_access_check(rand_addr(2'b00), 1'b0, bank, rom);
		mem_access_check(rand_addr(2'b01), 1'b0, bank, rom);
		mem_access_check(rand_addr(2'b11), 1'b0, bank, rom);
	endtask

	task automatic next_tick_p(input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
		end while (!ce_cpu_p && cycles < limit);
		if (!ce_cpu_p) begin
			other_errors++;
			$display("No ce_cpu_p within %0d cycles at %0t", limit, $time);
		end
	endtask

	// Let the FSM react to the last change, then count rising ticks over two periods
	task automatic tick_count_check(input int period, input int exp);
		int n;
		n = 0;
		repeat (period + 2) @(negedge clk_sys);
		repeat (2 * period) begin
			@(negedge clk_sys);
			if (ce_cpu_p)
				n++;
		end
		check_count("ce_cpu_p count", n, exp);
	endtask

	// ==========================================================
	// Tests
	// ==========================================================
	task automatic test_default_map;
		check_map(3'd0, 1'b0);
		mem_access_check(rand_addr(2'b10), 1'b0, 3'd0, 1'b0);
		mem_access_check(rand_addr(2'b00), 1'b1, 3'd0, 1'b0);
		mem_access_check(rand_addr(2'b00), 1'b1, 3'd0, 1'b0);
		mem_access_check(rand_addr(2'b10), 1'b1, 3'd0, 1'b0);
	endtask

	task automatic test_paging;
		cpu_data_t page;
		cpu_data_t locked;
		page = cpu_data_t'(rand_bits(8)) & 8'hDF;
		io_write(16'h7FFD, page);
		check_map(page[2:0], page[4]);
		// Lock bit freezes the map until reset
		locked = cpu_data_t'(rand_bits(8)) | 8'h20;
		io_write(16'h7FFD, locked);
		check_map(locked[2:0], locked[4]);
		io_write(16'h7FFD, locked ^ 8'h17);
		check_map(locked[2:0], locked[4]);
		// 48K machine ignores the port and stays on ROM 1
		apply_reset(1'b1);
		io_write(16'h7FFD, (cpu_data_t'(rand_bits(8)) & 8'hC8) | 8'h07);
		check_map(3'd0, 1'b1);
		apply_reset(1'b0);
		io_write(16'h7FFD, page);
		check_map(page[2:0], page[4]);
	endtask

	task automatic test_ula_latch;
		cpu_data_t data;
		ula_out_t  exp;
		repeat (3) begin
			data = cpu_data_t'(rand_bits(8));
			io_write({cpu_data_t'(rand_bits(8)), 8'hFE}, data);
			exp.border = data[2:0];
			exp.mic    = data[3];
			exp.ear    = data[4];
			@(negedge clk_sys);
			check_ula("ula_out", ula_out, exp);
		end
	endtask

	task automatic test_read_mux;
		logic [4:0] keys;
		logic       tape;
		cpu_data_t  mem;
		repeat (3) begin
			keys = 5'(rand_bits(5));
			tape = 1'(rand_bits(1));
			mem  = cpu_data_t'(rand_bits(8));
			@(negedge clk_sys);
			key_row = keys;
			tape_in = tape;
			drive_bus(cpu_addr_t'({rand_bits(15), 1'b0}), 8'h00, 1'b0, 1'b1, 1'b1, 1'b0);
			#25;
			check_data("cpu_din", cpu_din, {1'b1, ~tape, 1'b1, keys});
			@(negedge clk_sys);
			drive_bus(cpu_addr_t'({rand_bits(15), 1'b1}), 8'h00, 1'b0, 1'b1, 1'b1, 1'b0);
			#25;
			check_data("cpu_din", cpu_din, 8'hFF);
			@(negedge clk_sys);
			ram_dout = mem;
			drive_bus(rand_addr(2'(rand_bits(2))), 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
			#25;
			check_data("cpu_din", cpu_din, mem);
		end
		bus = '0;
	endtask

	task automatic test_turbo;
		int sel;
		int period;
		int wait_n;
		int gap;
		int spacing;
		int offset;
		for (int i = 1; i <= 5; i++) begin
			sel    = i % 5;
			period = expected_period(sel);
			@(negedge clk_sys);
			turbo_sel = 3'(sel);
			// The falling tick that loads the new speed still runs at the old one
			wait_n = 0;
			while (!ce_cpu_n && wait_n < 64) begin
				@(negedge clk_sys);
				wait_n++;
			end
			gap = 0;
			do begin
				@(negedge clk_sys);
				gap++;
				if (ce_cpu_n) begin
					other_errors++;
					$display("ce_cpu_n seen during turbo settle at %0t", $time);
				end
			end while (!ce_cpu_p && gap < 4 * period);
			// Three falling ticks of settle come before the next rising tick
			if (!ce_cpu_p || gap < 2 * period + 2) begin
				other_errors++;
				$display("Turbo select %0d: first ce_cpu_p after %0d cycles, too early or missing",
					sel, gap);
			end
			repeat (3) begin
				next_tick_p(2 * period, spacing);
				check_count("ce_cpu_p spacing", spacing, period);
			end
			// Falling phase comes half a period after the rising one
			offset = 0;
			do begin
				@(negedge clk_sys);
				offset++;
			end while (!ce_cpu_n && offset < period);
			check_count("ce_cpu_n offset", offset, period / 2);
		end
	endtask

	task automatic test_pause_and_wait;
		@(negedge clk_sys);
		pause = 1'b1;
		tick_count_check(32, 0);
		@(negedge clk_sys);
		pause = 1'b0;
		tick_count_check(32, 2);
		// 8x outruns the memory and waits for it
		@(negedge clk_sys);
		turbo_sel = 3'd3;
		repeat (64) @(negedge clk_sys);
		ram_ready = 1'b0;
		tick_count_check(4, 0);
		@(negedge clk_sys);
		ram_ready = 1'b1;
		tick_count_check(4, 2);
		@(negedge clk_sys);
		turbo_sel = 3'd0;
		repeat (128) @(negedge clk_sys);
		ram_ready = 1'b0;
		tick_count_check(32, 2);
		@(negedge clk_sys);
		ram_ready = 1'b1;
	endtask

	initial begin
		reset       = 1'b1;
		bus         = '0;
		turbo_sel   = 3'd0;
		pause       = 1'b0;
		machine_48k = 1'b0;
		key_row     = 5'h1F;
		tape_in     = 1'b0;
		ram_dout    = 8'h00;
		ram_ready   = 1'b1;
		apply_reset(1'b0);
		test_default_map();
		test_paging();
		test_ula_latch();
		test_read_mux();
		test_turbo();
		test_pause_and_wait();
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: verilog/ce_timer.sv
/*
 * CPU clock-enable timer
 * Free-running counter masked by the applied turbo gives the two CPU phases
 */
module ce_timer
	import zx_host_pkg::*;
(
	input  logic   clk_sys,
	input  logic   reset,
	input  turbo_t turbo,
	output logic   tick_p,
	output logic   tick_n
);

	logic [5:0] counter;
	logic [5:0] masked;
	logic [5:0] half_mark;

	// Counter runs every cycle, turbo only selects which bits matter
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
		end else begin
			counter <= counter + 6'd1;
		end
	end

	assign masked = counter & {1'b0, turbo};

	// Top set bit of the mask marks half a period
	assign half_mark = {1'b0, turbo ^ {1'b0, turbo[4:1]}};

	// Rising phase at the start of every period
	assign tick_p = (masked == 6'd0);

	// Falling phase half a period later, next cycle at 16x
	assign tick_n = (masked == half_mark);

endmodule

// File: verilog/cpu_enable_fsm.sv
/*
 * CPU enable state machine
 * Holds the applied turbo and gates CPU ticks on turbo settle, RAM wait and pause
 */
`include "zx_host_params.svh"

module cpu_enable_fsm
	import zx_host_pkg::*;
(
	input  logic   clk_sys,
	input  logic   reset,
	input  logic   tick_n,
	input  turbo_t turbo_req,
	input  logic   ram_ready,
	input  logic   pause,
	output logic   cpu_en,
	output turbo_t turbo
);

	cpu_en_state_t state;
	logic [1:0]    settle_cnt;
	logic          fast;

	// 4x and up outrun the memory, so only they wait on ram_ready
	assign fast = (turbo[4:3] == 2'b00);

	// ==========================================================
	// State update, only on falling-phase ticks
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= RUN;
			turbo      <= `ZX_TURBO_1X;
			settle_cnt <= '0;
		end else if (tick_n) begin
			if (turbo_req != turbo) begin
				// New speed, hold the CPU while the phases realign
				turbo      <= turbo_req;
				settle_cnt <= 2'(`ZX_SETTLE_TICKS);
				state      <= SETTLE;
			end else begin
				case (state)
					RUN: begin
						if (pause) begin
							state <= PAUSED;
						end else if (fast && !ram_ready) begin
							state <= WAIT_RAM;
						end
					end
					SETTLE: begin
						if (settle_cnt == 2'd1) begin
							state <= (ram_ready && !pause) ? RUN : PAUSED;
						end
						settle_cnt <= settle_cnt - 2'd1;
					end
					WAIT_RAM: begin
						if (ram_ready) begin
							state <= RUN;
						end
					end
					PAUSED: begin
						if (!pause) begin
							state <= RUN;
						end
					end
					default: state <= RUN;
				endcase
			end
		end
	end

	assign cpu_en = (state == RUN);

endmodule

// File: verilog/memory_pager.sv
/*
 * 128K memory pager
 * Port 7FFD paging register and the map from CPU address to RAM or ROM request
 */
`include "zx_host_params.svh"

module memory_pager
	import zx_host_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_bus_t  bus,
	input  logic      machine_48k,
	output cpu_data_t cpu_din_mem,
	input  cpu_data_t ram_dout,
	output ram_req_t  ram_req,
	output logic      mem_access
);

	// Layout of the 7FFD register, top two bits unused
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;
		logic       rom_sel;
		logic       screen;
		bank_t      bank;
	} page_reg_t;

	page_reg_t page;
	logic      zx48;
	logic      io_wr;
	logic      io_wr_d;
	logic      page_write;
	logic      rom_sel;

	assign io_wr      = bus.iorq & bus.wr & ~bus.m1;
	assign page_write = `ZX_PAGE_PORT(bus.addr) & ~page.lock & ~zx48;

	// ==========================================================
	// Paging register
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		io_wr_d <= io_wr;
		if (reset) begin
			page    <= '0;
			zx48    <= machine_48k;
			io_wr_d <= 1'b0;
		end else if (io_wr && !io_wr_d && page_write) begin
			// Once per access, on its first cycle
			page <= page_reg_t'(bus.dout);
		end
	end

	// ==========================================================
	// Address map
	// ==========================================================

	// 48K machine always runs the 48 BASIC ROM
	assign rom_sel = zx48 | page.rom_sel;

	always_comb begin
		case (bus.addr[15:14])
			2'b00:   ram_req.addr = `ZX_ROM_BASE + {3'b000, rom_sel, bus.addr[13:0]};
			2'b01:   ram_req.addr = {1'b0, `ZX_BANK_4000, bus.addr[13:0]};
			2'b10:   ram_req.addr = {1'b0, `ZX_BANK_8000, bus.addr[13:0]};
			default: ram_req.addr = {1'b0, page.bank, bus.addr[13:0]};
		endcase
	end

	assign ram_req.din = bus.dout;
	assign ram_req.rd  = bus.mreq & bus.rd;

	// ROM area is write protected
	assign ram_req.we  = bus.mreq & bus.wr & (bus.addr[15:14] != 2'b00);

	assign mem_access  = bus.mreq;
	assign cpu_din_mem = ram_dout;

endmodule

// File: verilog/ula_port.sv
/*
 * ULA port
 * Border, ear and mic latch on even I/O writes, and the CPU read-data multiplexer
 */
module ula_port
	import zx_host_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  logic       mem_access,
	input  cpu_data_t  mem_data,
	input  logic [4:0] key_row,
	input  logic       tape_in,
	output ula_out_t   ula_out,
	output cpu_data_t  cpu_din
);

	logic ula_we;
	logic ula_we_d;
	logic io_rd;

	// Any even I/O address selects the ULA
	assign ula_we = bus.iorq & bus.wr & ~bus.m1 & ~bus.addr[0];
	assign io_rd  = bus.iorq & bus.rd & ~bus.m1;

	// ==========================================================
	// Output latch
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		ula_we_d <= ula_we;
		if (reset) begin
			ula_out.ear <= 1'b0;
			ula_out.mic <= 1'b0;
			ula_we_d    <= 1'b0;
		end else if (ula_we && !ula_we_d) begin
			ula_out.border <= bus.dout[2:0];
			ula_out.mic    <= bus.dout[3];
			ula_out.ear    <= bus.dout[4];
		end
	end

	// ==========================================================
	// Read data
	// ==========================================================
	always_comb begin
		if (mem_access) begin
			cpu_din = mem_data;
		end else if (io_rd && !bus.addr[0]) begin
			// Keys are active low, unused bits float high
			cpu_din = {1'b1, ~tape_in, 1'b1, key_row};
		end else begin
			cpu_din = 8'hFF;
		end
	end

endmodule

// File: verilog/zx_host_pkg.sv
/*
 * ZX host shared types
 * Bus vectors, request structs and the CPU-enable state encoding
 */
`include "zx_host_params.svh"

package zx_host_pkg;

	// ==========================================================
	// Plain vector types
	// ==========================================================
	typedef logic [`ZX_ADDR_W-1:0]     cpu_addr_t;
	typedef logic [`ZX_DATA_W-1:0]     cpu_data_t;
	typedef logic [`ZX_RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [`ZX_BANK_W-1:0]     bank_t;
	typedef logic [`ZX_TURBO_W-1:0]    turbo_t;

	// ==========================================================
	// Structs
	// ==========================================================

	// CPU side of the bus, strobes active high
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t dout;
		logic      mreq;
		logic      iorq;
		logic      rd;
		logic      wr;
		logic      m1;
	} cpu_bus_t;

	// Request to the memory, valid while rd or we is high
	typedef struct packed {
		ram_addr_t addr;
		cpu_data_t din;
		logic      rd;
		logic      we;
	} ram_req_t;

	// ULA output latch
	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_out_t;

	typedef enum logic [1:0] {
		RUN,
		SETTLE,
		WAIT_RAM,
		PAUSED
	} cpu_en_state_t;

endpackage

// File: verilog/zx_host_top.sv
/*
 * ZX Spectrum 128K host core
 * Clock enables, CPU gating, memory paging and the ULA port around an external Z80
 */
`include "zx_host_params.svh"

module zx_host_top
	import zx_host_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  logic [2:0] turbo_sel,
	input  logic       pause,
	input  logic       machine_48k,
	input  logic [4:0] key_row,
	input  logic       tape_in,
	input  cpu_data_t  ram_dout,
	input  logic       ram_ready,
	output ram_req_t   ram_req,
	output cpu_data_t  cpu_din,
	output ula_out_t   ula_out,
	output logic       ce_cpu_p,
	output logic       ce_cpu_n
);

	turbo_t    turbo_req;
	turbo_t    turbo;
	logic      tick_p;
	logic      tick_n;
	logic      cpu_en;
	logic      mem_access;
	cpu_data_t mem_data;

	// Speed select, out of range codes fall back to 1x
	always_comb begin
		case (turbo_sel)
			3'd1:    turbo_req = `ZX_TURBO_2X;
			3'd2:    turbo_req = `ZX_TURBO_4X;
			3'd3:    turbo_req = `ZX_TURBO_8X;
			3'd4:    turbo_req = `ZX_TURBO_16X;
			default: turbo_req = `ZX_TURBO_1X;
		endcase
	end

	ce_timer ce_timer_i (.clk_sys, .reset, .turbo, .tick_p, .tick_n);

	cpu_enable_fsm cpu_enable_fsm_i (
		.clk_sys, .reset, .tick_n, .turbo_req, .ram_ready, .pause, .cpu_en, .turbo
	);

	assign ce_cpu_p = tick_p & cpu_en;
	assign ce_cpu_n = tick_n & cpu_en;

	memory_pager memory_pager_i (
		.clk_sys, .reset, .bus, .machine_48k, .cpu_din_mem(mem_data), .ram_dout,
		.ram_req, .mem_access
	);

	ula_port ula_port_i (
		.clk_sys, .reset, .bus, .mem_access, .mem_data, .key_row, .tape_in,
		.ula_out, .cpu_din
	);

endmodule
